// File: spi_defs.svh
// SPI master parameters

`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

//////////////////////////////////////////////////
// Word and prescaler sizes
//////////////////////////////////////////////////

// Number of bits shifted in one frame.
`define SPI_WORD_LEN 8

// Width of the prescaler code. Code p gives half periods of 2^(p+1) clocks.
`define SPI_PRESC_BITS 3

// Width of the prescaler counter. It must hold the largest limit,
// which is 2^(2^SPI_PRESC_BITS) - 1 = 255 for a 3-bit code.
`define SPI_PRESC_CNT_BITS 8

`endif

// File: spi_pkg.sv
// SPI master types

`include "spi_defs.svh"

package spi_pkg;

    //////////////////////////////////////////////////
    // Data and configuration types
    //////////////////////////////////////////////////

    // One data word as sent or received on the bus.
    typedef logic [`SPI_WORD_LEN-1:0] word_t;

    // SPI mode. Bit 1 is the clock polarity and bit 0 is the clock phase.
    typedef logic [1:0] spi_mode_t;

    // Settings that travel with each word. They are fixed for a whole frame.
    typedef struct packed {
        spi_mode_t                  mode;      // Polarity and phase.
        logic                       lsbfirst;  // Set to shift the LSB first.
        logic [`SPI_PRESC_BITS-1:0] presc;     // Prescaler code.
    } spi_cfg_t;

    //////////////////////////////////////////////////
    // Engine state
    //////////////////////////////////////////////////

    // The shift engine is either waiting for a word or running a frame.
    typedef enum logic {
        st_idle = 1'b0,
        st_busy = 1'b1
    } engine_state_t;

endpackage

// File: spi_word_if.sv
// Word transfer interface

`timescale 1ns/1ps

interface spi_word_if;

    // On the transmit path full means a word is waiting and take pops it.
    // On the receive path full is a one-cycle valid and only data goes with it.
    logic              full;
    spi_pkg::word_t    data;
    spi_pkg::spi_cfg_t cfg;
    logic              take;

    // Side that owns the word.
    modport source (
        output full,
        output data,
        output cfg,
        input  take
    );

    // Side that consumes the word.
    modport sink (
        input  full,
        input  data,
        input  cfg,
        output take
    );

endinterface

// File: spi_tx_buffer.sv
// SPI transmit buffer

`timescale 1ns/1ps

module spi_tx_buffer (
    input  logic              wr,            // System clock.
    input  logic              rst,           // Asynchronous reset, active high.
    input  logic              tx_write,      // One-cycle write strobe.
    input  spi_pkg::word_t    tx_data,       // Word to be sent.
    input  spi_pkg::spi_cfg_t cfg_in,        // Settings captured with the word.
    input  logic              rst_tx_error,  // Clears the sticky error.
    output logic              tx_completed,  // High while the buffer is empty.
    output logic              tx_error,      // Sticky overrun flag.
    spi_word_if.source        tx             // Word to the shift engine.
);

    logic              full;    // A word is waiting for the engine.
    spi_pkg::word_t    data_r;  // Held word.
    spi_pkg::spi_cfg_t cfg_r;   // Settings of the held word.

    //////////////////////////////////////////////////
    // Buffer flags
    //////////////////////////////////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            full     <= 1'b0;
            tx_error <= 1'b0;
        end else begin
            // The engine only takes while full, so take and an accepted write never meet.
            if (tx.take) begin
                full <= 1'b0;
            end else if (tx_write && !full) begin
                full <= 1'b1;  // Write accepted.
            end
            // Clearing wins over a refused write in the same cycle.
            if (rst_tx_error) begin
                tx_error <= 1'b0;
            end else if (tx_write && full) begin
                tx_error <= 1'b1;  // Overrun. The held word is kept.
            end
        end
    end

    // Word and settings are captured together and stay put while full.
    always_ff @(posedge wr) begin
        if (tx_write && !full) begin
            data_r <= tx_data;
            cfg_r  <= cfg_in;
        end
    end

    assign tx_completed = ~full;  // Empty again in the cycle after take.
    assign tx.full      = full;
    assign tx.data      = data_r;
    assign tx.cfg       = cfg_r;

    // The engine must never pop an empty buffer.
    a_take_needs_full : assert property (
        @(posedge wr) disable iff (rst) tx.take |-> full
    );

endmodule

// File: spi_shift_engine.sv
// SPI frame engine

`timescale 1ns/1ps

`include "spi_defs.svh"

module spi_shift_engine (
    input  logic              wr,         // System clock.
    input  logic              rst,        // Asynchronous reset, active high.
    spi_word_if.sink          tx,         // Word from the transmit buffer.
    spi_word_if.source        rx,         // Received word to the receive buffer.
    input  spi_pkg::spi_mode_t mode_idle, // Live mode. Sets the sck level between frames.
    input  logic              miso,       // Serial data from the slave.
    output logic              sck,        // Serial clock.
    output logic              mosi,       // Serial data to the slave.
    output logic              ss          // Slave select, active low.
);

    localparam int word_len = `SPI_WORD_LEN;
    localparam int cnt_w    = `SPI_PRESC_CNT_BITS;
    localparam int half_w   = $clog2(2 * word_len + 1);  // Holds 0 to 2 * word_len.

    spi_pkg::engine_state_t state;
    spi_pkg::spi_cfg_t      cfg_r;       // Settings of the running frame.
    logic [cnt_w-1:0]       presc_cnt;   // Clocks spent in the current half period.
    logic [cnt_w-1:0]       presc_lim;   // Last count of a half period.
    logic [half_w-1:0]      half_cnt;    // Half periods done. Bit 0 is the internal clock.
    logic [half_w-1:0]      last_half;   // Half period on which the frame ends.
    spi_pkg::word_t         shift_tx;    // Bits still to be sent.
    spi_pkg::word_t         shift_rx;    // Bits collected so far.
    logic                   mosi_r;      // Bit presented while ss is low.
    logic                   rx_valid;    // One-cycle strobe for a finished word.
    logic                   first_bit;   // First bit of the waiting word.
    logic                   tick;        // End of a half period.
    logic                   sample_ph;   // Current half period ends on a sampling edge.
    logic                   frame_end;   // Final tick of the frame.
    logic                   pol;         // Polarity in use on the sck pin.

    //////////////////////////////////////////////////
    // Timing decode
    //////////////////////////////////////////////////

    // A half period lasts presc_lim + 1 = 2^(p+1) clocks.
    assign presc_lim = cnt_w'((32'd1 << (32'(cfg_r.presc) + 32'd1)) - 32'd1);

    assign tick = (state == spi_pkg::st_busy) && (presc_cnt == presc_lim);

    // Phase 0 samples on the edges leaving even half periods and phase 1 on odd ones.
    assign sample_ph = (half_cnt[0] == cfg_r.mode[0]);

    // Phase 0 has no trailing half period after the last sample. Phase 1 has one.
    assign last_half = cfg_r.mode[0] ? half_w'(2 * word_len) : half_w'(2 * word_len - 1);

    assign frame_end = tick && !sample_ph && (half_cnt == last_half);

    assign first_bit = tx.cfg.lsbfirst ? tx.data[0] : tx.data[word_len-1];

    // Pop the buffer as soon as a word waits and no frame runs.
    assign tx.take = (state == spi_pkg::st_idle) && tx.full;

    //////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            state     <= spi_pkg::st_idle;
            cfg_r     <= '0;
            presc_cnt <= '0;
            half_cnt  <= '0;
            ss        <= 1'b1;
            mosi_r    <= 1'b1;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                spi_pkg::st_idle: begin
                    if (tx.full) begin
                        state     <= spi_pkg::st_busy;
                        cfg_r     <= tx.cfg;       // Settings are frozen here.
                        presc_cnt <= '0;
                        half_cnt  <= '0;
                        ss        <= 1'b0;
                        // Phase 0 needs the first bit valid before the first edge.
                        mosi_r    <= tx.cfg.mode[0] ? 1'b1 : first_bit;
                    end
                end
                spi_pkg::st_busy: begin
                    if (!tick) begin
                        presc_cnt <= presc_cnt + 1'b1;
                    end else begin
                        presc_cnt <= '0;
                        if (frame_end) begin
                            state    <= spi_pkg::st_idle;
                            half_cnt <= '0;          // sck back to its idle level.
                            ss       <= ~tx.full;    // Stay selected for a waiting word.
                            rx_valid <= 1'b1;
                        end else begin
                            half_cnt <= half_cnt + 1'b1;
                            // Shifting edge. Put the next bit out.
                            if (!sample_ph) begin
                                mosi_r <= cfg_r.lsbfirst ? shift_tx[0] : shift_tx[word_len-1];
                            end
                        end
                    end
                end
                default: state <= spi_pkg::st_idle;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Shift registers
    //////////////////////////////////////////////////

    always_ff @(posedge wr) begin
        if (tx.take) begin
            shift_tx <= tx.data;
        end else if (tick && sample_ph) begin
            // Sampling edge. Capture miso and advance the transmit word with a fill of 1.
            if (cfg_r.lsbfirst) begin
                shift_rx <= {miso, shift_rx[word_len-1:1]};
                shift_tx <= {1'b1, shift_tx[word_len-1:1]};
            end else begin
                shift_rx <= {shift_rx[word_len-2:0], miso};
                shift_tx <= {shift_tx[word_len-2:0], 1'b1};
            end
        end
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    // Between separate frames the live mode decides the idle level.
    assign pol  = ss ? mode_idle[1] : cfg_r.mode[1];
    assign sck  = pol ^ half_cnt[0];
    assign mosi = ss ? 1'b1 : mosi_r;  // Line rests high while deselected.

    assign rx.full = rx_valid;
    assign rx.data = shift_rx;

    // Outside a frame ss stays low only while the next word is still queued.
    a_ss_low_in_frame : assert property (
        @(posedge wr) disable iff (rst) !ss |-> (state == spi_pkg::st_busy) || tx.full
    );

    a_presc_in_range : assert property (
        @(posedge wr) disable iff (rst) presc_cnt <= presc_lim
    );

endmodule

// File: spi_rx_buffer.sv
// SPI receive buffer

`timescale 1ns/1ps

module spi_rx_buffer (
    input  logic           wr,            // System clock.
    input  logic           rst,           // Asynchronous reset, active high.
    spi_word_if.sink       rx,            // Finished words from the engine.
    input  logic           rd,            // One-cycle read acknowledge.
    output spi_pkg::word_t rx_data,       // Last received word.
    output logic           rx_completed   // Set while an unread word is held.
);

    //////////////////////////////////////////////////
    // Word capture
    //////////////////////////////////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            rx_data      <= '0;
            rx_completed <= 1'b0;
        end else if (rx.full) begin
            // A new word replaces an unread one. It also wins over rd.
            rx_data      <= rx.data;
            rx_completed <= 1'b1;
        end else if (rd) begin
            rx_completed <= 1'b0;  // Word has been read.
        end
    end

    // The held word moves only when the engine hands over a new one.
    a_data_on_valid : assert property (
        @(posedge wr) disable iff (rst) $changed(rx_data) |-> $past(rx.full)
    );

endmodule

// File: spi_master.sv
// SPI master top level

`timescale 1ns/1ps

`include "spi_defs.svh"

module spi_master (
    input  logic                       wr,            // System clock.
    input  logic                       rst,           // Asynchronous reset, active high.
    input  logic                       tx_write,      // Write strobe for tx_data.
    input  spi_pkg::word_t             tx_data,       // Word to transmit.
    input  spi_pkg::spi_mode_t         mode,          // SPI mode 0 to 3.
    input  logic                       lsbfirst,      // Bit order of the next word.
    input  logic [`SPI_PRESC_BITS-1:0] prescaler,     // Half period is 2^(p+1) clocks.
    input  logic                       rst_tx_error,  // Clears tx_error.
    input  logic                       rd,            // Read acknowledge for rx_data.
    input  logic                       miso,          // Serial data from the slave.
    output logic                       tx_completed,  // Transmit buffer is free.
    output logic                       tx_error,      // Write was made while busy.
    output logic                       rx_completed,  // A received word is waiting.
    output spi_pkg::word_t             rx_data,       // Last received word.
    output logic                       sck,           // Serial clock.
    output logic                       mosi,          // Serial data to the slave.
    output logic                       ss             // Slave select, active low.
);

    spi_pkg::spi_cfg_t cfg;  // Settings captured with each write.

    //////////////////////////////////////////////////
    // Configuration and links
    //////////////////////////////////////////////////

    assign cfg.mode     = mode;
    assign cfg.lsbfirst = lsbfirst;
    assign cfg.presc    = prescaler;

    spi_word_if tx_word ();  // Buffer to engine.
    spi_word_if rx_word ();  // Engine to receive buffer.

    //////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////

    spi_tx_buffer i_tx_buffer (
        .wr           (wr),
        .rst          (rst),
        .tx_write     (tx_write),
        .tx_data      (tx_data),
        .cfg_in       (cfg),
        .rst_tx_error (rst_tx_error),
        .tx_completed (tx_completed),
        .tx_error     (tx_error),
        .tx           (tx_word.source)
    );

    // The engine also sees the live mode so sck idles correctly outside frames.
    spi_shift_engine i_shift_engine (
        .wr        (wr),
        .rst       (rst),
        .tx        (tx_word.sink),
        .rx        (rx_word.source),
        .mode_idle (mode),
        .miso      (miso),
        .sck       (sck),
        .mosi      (mosi),
        .ss        (ss)
    );

    spi_rx_buffer i_rx_buffer (
        .wr           (wr),
        .rst          (rst),
        .rx           (rx_word.sink),
        .rd           (rd),
        .rx_data      (rx_data),
        .rx_completed (rx_completed)
    );

endmodule

// File: tb_spi_master.sv
// SPI master testbench

`timescale 1ns/1ps

`include "spi_defs.svh"

module tb_spi_master;

    localparam int word_len       = `SPI_WORD_LEN;
    localparam int n_entries      = 10;
    localparam int timeout_cycles = n_entries * (2 * word_len + 2) * 256 + 200;

    // One row of the stimulus table.
    typedef struct packed {
        spi_pkg::word_t             tx;     // Word the master sends.
        spi_pkg::word_t             miso;   // Word the slave answers with.
        spi_pkg::spi_mode_t         mode;
        logic                       lsb;    // Set for LSB first.
        logic [`SPI_PRESC_BITS-1:0] presc;
        logic                       b2b;    // Written while the previous frame runs.
    } entry_t;

    logic                       wr = 1'b0;
    logic                       rst = 1'b1;
    logic                       tx_write = 1'b0;
    spi_pkg::word_t             tx_data = '0;
    spi_pkg::spi_mode_t         mode = 2'b10;  // Idle-high sck before the first frame.
    logic                       lsbfirst = 1'b0;
    logic [`SPI_PRESC_BITS-1:0] prescaler = '0;
    logic                       rst_tx_error = 1'b0;
    logic                       rd = 1'b0;
    logic                       miso = 1'b1;
    logic                       tx_completed;
    logic                       tx_error;
    logic                       rx_completed;
    spi_pkg::word_t             rx_data;
    logic                       sck;
    logic                       mosi;
    logic                       ss;

    entry_t         tbl [n_entries];
    string          names [n_entries];
    int             n_used = 0;
    logic [31:0]    rng = 32'h5fdc_6f2e;
    int             errors = 0;
    int unsigned    cycles = 0;
    int             slave_q [$];     // Table rows the slave still has to serve.
    spi_pkg::word_t captured_q [$];  // Words the slave collected from mosi.
    entry_t         s_entry;         // Row the slave is serving now.
    spi_pkg::word_t s_cap;
    int             s_nsamp = 0;     // Sampling edges seen in the current word.
    logic           s_loaded = 1'b0;
    logic           prev_sck = 1'b1;
    logic           prev_ss = 1'b1;

    spi_master i_dut (
        .wr           (wr),
        .rst          (rst),
        .tx_write     (tx_write),
        .tx_data      (tx_data),
        .mode         (mode),
        .lsbfirst     (lsbfirst),
        .prescaler    (prescaler),
        .rst_tx_error (rst_tx_error),
        .rd           (rd),
        .miso         (miso),
        .tx_completed (tx_completed),
        .tx_error     (tx_error),
        .rx_completed (rx_completed),
        .rx_data      (rx_data),
        .sck          (sck),
        .mosi         (mosi),
        .ss           (ss)
    );

    always #50 wr = ~wr;  // 100 ns period.

    always @(posedge wr) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout after %0d cycles, a frame never completed.", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Word bit that travels as the n-th bit on the wire.
    function automatic int wire_bit(input logic lsb, input int n);
        return lsb ? n : word_len - 1 - n;
    endfunction

    task automatic add_entry(input string name, input spi_pkg::spi_mode_t m, input logic lsb,
                             input int p, input logic b2b);
        rng = xorshift32(rng);
        tbl[n_used].tx = rng[word_len-1:0];
        rng = xorshift32(rng);
        tbl[n_used].miso  = rng[word_len-1:0];
        tbl[n_used].mode  = m;
        tbl[n_used].lsb   = lsb;
        tbl[n_used].presc = p[`SPI_PRESC_BITS-1:0];
        tbl[n_used].b2b   = b2b;
        names[n_used]     = name;
        n_used++;
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("FAILED %s: %s expected 0x%0h, actual 0x%0h", name, what, exp, act);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    // Starts on a rising edge and leaves on the edge where the DUT saw the write.
    task automatic write_word(input int i);
        tx_data   <= tbl[i].tx;
        mode      <= tbl[i].mode;
        lsbfirst  <= tbl[i].lsb;
        prescaler <= tbl[i].presc;
        tx_write  <= 1'b1;
        slave_q.push_back(i);  // The slave answers this row.
        @(posedge wr);
        tx_write <= 1'b0;
    endtask

    task automatic start_frame(input int i);
        do @(posedge wr); while (!(tx_completed && ss));
        mode <= tbl[i].mode;  // sck should follow the live mode while idle.
        @(posedge wr);
        if (ss !== 1'b1) report_mismatch(names[i], "ss between frames", 1, ss);
        if (sck !== tbl[i].mode[1]) report_mismatch(names[i], "idle sck", tbl[i].mode[1], sck);
        write_word(i);
    endtask

    // Queues row j during the running frame, then tries an overrun and clears the error.
    task automatic queue_next(input int j);
        do @(posedge wr); while (!tx_completed);
        write_word(j);
        @(posedge wr);
        if (tx_completed !== 1'b0) report_mismatch(names[j], "tx_completed", 0, tx_completed);
        tx_data  <= ~tbl[j].tx;  // Refused. Must not reach the wire.
        tx_write <= 1'b1;
        @(posedge wr);
        tx_write <= 1'b0;
        @(posedge wr);
        if (tx_error !== 1'b1) report_mismatch(names[j], "tx_error after overrun", 1, tx_error);
        rst_tx_error <= 1'b1;
        @(posedge wr);
        rst_tx_error <= 1'b0;
        @(posedge wr);
        if (tx_error !== 1'b0) report_mismatch(names[j], "tx_error after clear", 0, tx_error);
    endtask

    task automatic wait_rx_done(input int i, input logic keep_selected);
        logic ss_high;
        ss_high = 1'b0;
        do begin
            @(posedge wr);
            if (keep_selected && ss) ss_high = 1'b1;
        end while (!rx_completed);
        if (ss_high) report_problem($sformatf("%s: ss went high before a queued word", names[i]));
    endtask

    task automatic check_word(input int i);
        spi_pkg::word_t cap;
        if (rx_data !== tbl[i].miso) report_mismatch(names[i], "rx_data", tbl[i].miso, rx_data);
        if (captured_q.size() == 0) begin
            report_problem($sformatf("%s: slave collected no word from mosi", names[i]));
        end else begin
            cap = captured_q.pop_front();
            if (cap !== tbl[i].tx) report_mismatch(names[i], "mosi word", tbl[i].tx, cap);
        end
        repeat (3) begin
            @(posedge wr);
            if (rx_completed !== 1'b1) begin
                report_mismatch(names[i], "rx_completed held", 1, rx_completed);
            end
        end
        rd <= 1'b1;
        @(posedge wr);
        rd <= 1'b0;
        @(posedge wr);
        if (rx_completed !== 1'b0) begin
            report_mismatch(names[i], "rx_completed after rd", 0, rx_completed);
        end
    endtask

    //////////////////////////////////////////////////
    // Slave model
    //////////////////////////////////////////////////

    task automatic load_next();
        s_entry  = tbl[slave_q.pop_front()];
        s_loaded = 1'b1;
        s_nsamp  = 0;
        miso <= s_entry.miso[wire_bit(s_entry.lsb, 0)];  // First bit ready before any edge.
    endtask

    // sck edges are seen one clock late, while mosi is still stable.
    always @(posedge wr) begin
        if (prev_ss && !ss && !s_loaded && slave_q.size() > 0) load_next();
        if (!ss && s_loaded && sck !== prev_sck) begin
            // Leading edges sample in phase 0, trailing edges in phase 1.
            if ((sck != s_entry.mode[1]) ^ s_entry.mode[0]) begin
                s_cap[wire_bit(s_entry.lsb, s_nsamp)] = mosi;
                s_nsamp++;
                if (s_nsamp == word_len) begin
                    captured_q.push_back(s_cap);
                    s_loaded = 1'b0;
                    if (slave_q.size() > 0) load_next();  // Back-to-back word.
                end
            end else begin
                miso <= s_entry.miso[wire_bit(s_entry.lsb, s_nsamp)];
            end
        end
        prev_sck = sck;
        prev_ss  = ss;
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        add_entry("m0_msb_p0", 2'd0, 1'b0, 0, 1'b0);
        add_entry("m1_msb_p1", 2'd1, 1'b0, 1, 1'b0);
        add_entry("m2_lsb_p0", 2'd2, 1'b1, 0, 1'b0);
        add_entry("m3_lsb_p3", 2'd3, 1'b1, 3, 1'b0);
        add_entry("m0_lsb_p1", 2'd0, 1'b1, 1, 1'b0);
        add_entry("m0_msb_p0_b2b", 2'd0, 1'b0, 0, 1'b1);  // Same mode as the row before.
        add_entry("m1_lsb_p0", 2'd1, 1'b1, 0, 1'b0);
        add_entry("m3_msb_p1", 2'd3, 1'b0, 1, 1'b0);
        add_entry("m3_lsb_p0_b2b", 2'd3, 1'b1, 0, 1'b1);
        add_entry("m2_msb_p3", 2'd2, 1'b0, 3, 1'b0);
        repeat (10) @(posedge wr);
        rst <= 1'b0;
        @(posedge wr);
        if (ss !== 1'b1) report_mismatch("reset", "ss", 1, ss);
        if (mosi !== 1'b1) report_mismatch("reset", "mosi", 1, mosi);
        if (sck !== mode[1]) report_mismatch("reset", "sck", mode[1], sck);
        if (tx_completed !== 1'b1) report_mismatch("reset", "tx_completed", 1, tx_completed);
        if (tx_error !== 1'b0) report_mismatch("reset", "tx_error", 0, tx_error);
        if (rx_completed !== 1'b0) report_mismatch("reset", "rx_completed", 0, rx_completed);
        if (rx_data !== '0) report_mismatch("reset", "rx_data", 0, rx_data);
        for (int i = 0; i < n_used; i++) begin
            if (!tbl[i].b2b) start_frame(i);
            if (i + 1 < n_used && tbl[i+1].b2b) begin
                queue_next(i + 1);
                wait_rx_done(i, 1'b1);
            end else begin
                wait_rx_done(i, 1'b0);
            end
            check_word(i);
        end
        $display("Ran %0d table entries, %0d errors.", n_used, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+.
spi_pkg.sv
spi_word_if.sv
spi_tx_buffer.sv
spi_shift_engine.sv
spi_rx_buffer.sv
spi_master.sv
tb_spi_master.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_master
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the simulation output holds the pass message.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
